//--- flist.f
+incdir+design
design/rob_pkg.sv
design/rob_alloc.sv
design/rob_store.sv
design/queue_room.sv
design/rob_commit.sv
design/rob_top.sv
tests/rob_asserts.sv
tests/tb_rob.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rob
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_STR ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_rob.sv
// Module tb_rob: clock, reset, reference model, directed tests, compare tasks and watchdog
`include "rob_params.svh"

module tb_rob import rob_pkg::*; ();

	localparam logic [31:0] seed = 32'h6ae8_0d73;
	localparam int mixed_cycles = 200;
	// Reset, fill, drain with its wait, hold and mixed phases
	localparam int test_cycles = 3 + 6 + 16 + 24 + 7 + mixed_cycles;

	logic clk = 1'b0;
	logic rst;
	disp_req_t disp;
	cmpl_t cmpl;
	hold_t hold;
	room_t room;
	cmt_rpt_t cmt;
	rob_ndx_t head;
	rob_ndx_t tail;

	int errors;
	logic [31:0] rng;

	// Shadow of the buffer state as the rules say it should be
	logic m_v [`ROB_ENTRIES];
	logic m_done [`ROB_ENTRIES];
	logic m_hwi [`ROB_ENTRIES];
	rob_tag_t m_tag [`ROB_ENTRIES];
	rob_ndx_t m_head;
	rob_ndx_t m_tail;
	logic m_empty;
	cmt_rpt_t m_cmt;
	room_t m_room;

	always #4 clk = ~clk;

	rob_top DUT (
		.clk(clk),
		.rst(rst),
		.disp(disp),
		.cmpl(cmpl),
		.hold(hold),
		.room(room),
		.cmt(cmt),
		.head(head),
		.tail(tail)
	);

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic cmpl_t make_cmpl(input rob_ndx_t ndx);
		cmpl_t c;
		c.valid = 1'b1;
		c.ndx = ndx;
		return c;
	endfunction

	function automatic hold_t make_hold(input logic set, input logic clr, input rob_ndx_t ndx);
		hold_t h;
		h.set = set;
		h.clr = clr;
		h.ndx = ndx;
		return h;
	endfunction

	// ========================================
	// Reference model
	// ========================================

	// Room from the free run ahead of the tail and where head sits in the window
	function automatic room_t model_room();
		int run_len;
		int head_at;
		rob_ndx_t s;
		room_t r;
		run_len = 0;
		head_at = `ROB_WIN;
		for (int k = 0; k < `ROB_WIN; k++) begin
			s = m_tail + rob_ndx_t'(k);
			if (head_at == `ROB_WIN && s == m_head)
				head_at = k;
			if (run_len == k && !m_v[s] && !m_hwi[s])
				run_len = k + 1;
		end
		if (m_empty)
			r = room_t'(`ROB_ENTRIES - 4);
		else
			r = (run_len >= 5) ? room_t'(4) : room_t'(0);
		for (int k = 4; k <= `ROB_WIN; k += 4) begin
			if (run_len >= k && head_at >= k)
				r = room_t'(k);
		end
		return r;
	endfunction

	function automatic void model_reset();
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			m_v[i] = 1'b0;
			m_done[i] = 1'b0;
			m_hwi[i] = 1'b0;
		end
		m_head = '0;
		m_tail = '0;
		m_empty = 1'b1;
		m_cmt = '0;
		m_room = model_room();
	endfunction

	// One clock edge, using the inputs that were on the DUT before it
	function automatic void model_step();
		int cnt;
		rob_ndx_t nxt;
		rob_ndx_t s;
		nxt = m_head + 4'd1;
		cnt = 0;
		if (m_v[m_head] && m_done[m_head]) begin
			cnt = 1;
			if (m_v[nxt] && m_done[nxt])
				cnt = 2;
		end
		m_cmt.count = cmt_cnt_t'(cnt);
		m_cmt.tags[0] = m_tag[m_head];
		m_cmt.tags[1] = m_tag[nxt];
		if (m_head != m_tail)
			m_empty = 1'b0;
		// Lowest priority first, so dispatch has the last word
		if (hold.clr)
			m_hwi[hold.ndx] = 1'b0;
		if (hold.set)
			m_hwi[hold.ndx] = 1'b1;
		if (cmpl.valid && m_v[cmpl.ndx])
			m_done[cmpl.ndx] = 1'b1;
		for (int k = 0; k < cnt; k++) begin
			s = m_head + rob_ndx_t'(k);
			m_v[s] = 1'b0;
			m_done[s] = 1'b0;
		end
		for (int j = 0; j < int'(disp.count); j++) begin
			s = m_tail + rob_ndx_t'(j);
			m_v[s] = 1'b1;
			m_done[s] = 1'b0;
			m_hwi[s] = 1'b0;
			m_tag[s] = disp.tags[j];
		end
		m_tail = m_tail + rob_ndx_t'(disp.count);
		m_head = m_head + rob_ndx_t'(cnt);
		m_room = model_room();
	endfunction

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_room(input room_t got, input room_t exp, input string what);
		if (got !== exp) begin
			$display("Error at time %0t: %s got %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_ndx(input rob_ndx_t got, input rob_ndx_t exp, input string what);
		if (got !== exp) begin
			$display("Error at time %0t: %s got %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// Only the tags the count covers carry meaning
	task automatic check_cmt(input cmt_rpt_t got, input cmt_rpt_t exp);
		if (got.count !== exp.count) begin
			$display("Error at time %0t: commit count got %0d, expected %0d",
				$time, got.count, exp.count);
			errors++;
		end
		else begin
			for (int k = 0; k < int'(got.count); k++) begin
				if (got.tags[k] !== exp.tags[k]) begin
					$display("Error at time %0t: commit tag %0d got %h, expected %h",
						$time, k, got.tags[k], exp.tags[k]);
					errors++;
				end
			end
		end
	endtask

	// Outputs are settled by the falling edge
	task automatic check_outputs();
		@(negedge clk);
		check_room(room, m_room, "room");
		check_ndx(head, m_head, "head");
		check_ndx(tail, m_tail, "tail");
		check_cmt(cmt, m_cmt);
	endtask

	// ========================================
	// Stimulus
	// ========================================

	task automatic advance();
		@(posedge clk);
		model_step();
	endtask

	// A group too big for room is dropped, and a hold never lands on a slot being written
	task automatic apply(input disp_cnt_t n, input cmpl_t c, input hold_t h);
		disp_req_t d;
		d = '0;
		if (room_t'(n) <= m_room)
			d.count = n;
		for (int j = 0; j < `ROB_DISP_W; j++) begin
			if (j < int'(d.count)) begin
				d.tags[j] = rob_tag_t'(next_rand());
				if (h.set && h.ndx == m_tail + rob_ndx_t'(j))
					h.set = 1'b0;
			end
		end
		disp <= d;
		cmpl <= c;
		hold <= h;
		check_outputs();
	endtask

	task automatic step(input disp_cnt_t n, input cmpl_t c, input hold_t h);
		advance();
		apply(n, c, h);
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic test_reset();
		check_room(room, 8'd12, "room after reset");
		check_ndx(head, 4'd0, "head after reset");
		check_ndx(tail, 4'd0, "tail after reset");
		check_cmt(cmt, '0);
	endtask

	// Four groups fit, then room closes
	task automatic test_fill();
		repeat (6) step(3'd4, '0, '0);
		check_room(room, 8'd0, "room when full");
	endtask

	task automatic test_drain();
		int order [16];
		order = '{3, 1, 2, 0, 7, 5, 6, 4, 9, 8, 11, 10, 15, 12, 13, 14};
		for (int i = 0; i < 16; i++) begin
			step(3'd0, make_cmpl(rob_ndx_t'(order[i])), '0);
			// Entry 0 is still outstanding, so nothing may have retired
			if (i == 3)
				check_ndx(head, 4'd0, "head stalled on a gap")
				;
		end
		// Head meets tail with room open again once the last entry has left
		for (int w = 0; w < 24; w++) begin
			if (head == tail && room != '0)
				break;
			step(3'd0, '0, '0);
		end
		if (!(head == tail && room != '0)) begin
			$display("Drain did not finish within 24 cycles");
			errors++;
		end
		check_ndx(head, 4'd0, "head after drain");
		check_ndx(tail, 4'd0, "tail after drain");
		// The empty flag stays clear, so only the five-slot rule gives room
		check_room(room, 8'd4, "room after drain");
	endtask

	task automatic test_hold();
		step(3'd4, '0, '0);
		step(3'd0, '0, '0);
		check_room(room, 8'd12, "room before hold");
		step(3'd0, '0, make_hold(1'b1, 1'b0, 4'd13));
		step(3'd0, '0, '0);
		check_room(room, 8'd8, "room with hold on slot 13");
		step(3'd0, '0, make_hold(1'b0, 1'b1, 4'd13));
		step(3'd0, '0, '0);
		check_room(room, 8'd12, "room after hold released");
	endtask

	task automatic test_mixed();
		disp_cnt_t n;
		cmpl_t c;
		hold_t h;
		rob_ndx_t s;
		rob_ndx_t start;
		for (int cyc = 0; cyc < mixed_cycles; cyc++) begin
			advance();
			n = disp_cnt_t'(next_rand() % 5);
			c = '0;
			h = '0;
			// Complete the first live entry that is not done yet, from a random start
			start = rob_ndx_t'(next_rand());
			for (int k = 0; k < `ROB_ENTRIES; k++) begin
				s = start + rob_ndx_t'(k);
				if (m_v[s] && !m_done[s]) begin
					c = make_cmpl(s);
					break;
				end
			end
			if (next_rand() % 8 == 0) begin
				s = rob_ndx_t'(next_rand());
				if (m_hwi[s])
					h = make_hold(1'b0, 1'b1, s);
				else if (!m_v[s])
					h = make_hold(1'b1, 1'b0, s);
			end
			apply(n, c, h);
		end
	endtask

	// ========================================
	// Run control
	// ========================================

	initial begin
		#(test_cycles * 8 + 400);
		$display("Watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rng = seed;
		errors = 0;
		rst = 1'b1;
		disp = '0;
		cmpl = '0;
		hold = '0;
		model_reset();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		test_reset();
		test_fill();
		test_drain();
		test_hold();
		test_mixed();
		$display("Checks finished with %0d errors and %0d assertion failures",
			errors, DUT.u_asserts.fail_count);
		if (errors == 0 && DUT.u_asserts.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- tests/rob_asserts.sv
// Module rob_asserts with bound checks on dispatch legality and pointer sanity, and its bind
`include "rob_params.svh"

module rob_asserts import rob_pkg::*; (
	input logic clk,
	input logic rst,
	input disp_req_t disp,
	input room_t room,
	input cmt_rpt_t cmt,
	input rob_ndx_t head,
	input rob_ndx_t tail,
	input rob_entry_t [`ROB_ENTRIES-1:0] rob
);

	// Number of live entries, a full buffer wraps to zero just like the pointer span
	rob_ndx_t live;
	// Failed assertions so far
	int fail_count = 0;

	always_comb begin
		live = '0;
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			live = live + rob_ndx_t'(rob[i].v);
		end
	end

	// ========================================
	// Dispatch legality
	// ========================================

	// Nothing in the design stops an oversized group, so the dispatcher must
	disp_in_room: assert property (@(posedge clk) disable iff (rst)
		room_t'(disp.count) <= room)
		else begin
			$error("Dispatch of %0d entries with room %0d", disp.count, room);
			fail_count++;
		end

	// ========================================
	// Pointer sanity
	// ========================================

	cmt_in_width: assert property (@(posedge clk) disable iff (rst)
		cmt.count <= cmt_cnt_t'(`ROB_CMT_W))
		else begin
			$error("Commit count %0d above the commit width", cmt.count);
			fail_count++;
		end

	// The live entries are exactly the run from head up to tail
	// Once head overtakes tail the span and the live count part ways
	head_behind_tail: assert property (@(posedge clk) disable iff (rst)
		rob_ndx_t'(tail - head) == live)
		else begin
			$error("Span from head %0d to tail %0d holds %0d live entries",
				head, tail, live);
			fail_count++;
		end

endmodule

bind rob_top rob_asserts u_asserts (
	.clk(clk),
	.rst(rst),
	.disp(disp),
	.room(room),
	.cmt(cmt),
	.head(head),
	.tail(tail),
	.rob(rob)
);

//--- design/rob_top.sv
// Module rob_top: reorder buffer top with tail allocation, storage, room estimate and commit
`include "rob_params.svh"

module rob_top import rob_pkg::*; (
	input logic clk,
	input logic rst,
	input disp_req_t disp,
	input cmpl_t cmpl,
	input hold_t hold,
	output room_t room,
	output cmt_rpt_t cmt,
	output rob_ndx_t head,
	output rob_ndx_t tail
);

	// ========================================
	// Internal wiring
	// ========================================

	// Window of consecutive slots starting at the tail
	rob_ndx_t [`ROB_WIN-1:0] tails;
	// Current entry array as seen by room and commit
	rob_entry_t [`ROB_ENTRIES-1:0] rob;
	// Entries being retired on the coming edge
	logic [`ROB_ENTRIES-1:0] retire_mask;

	// Tail pointer and the slot window derived from it
	rob_alloc u_alloc (
		.clk(clk),
		.rst(rst),
		.disp(disp),
		.tail(tail),
		.tails(tails)
	);

	// Entry flags and tags
	rob_store u_store (
		.clk(clk),
		.rst(rst),
		.disp(disp),
		.tails(tails),
		.cmpl(cmpl),
		.hold(hold),
		.retire_mask(retire_mask),
		.rob(rob)
	);

	// How much the dispatcher may write this cycle
	queue_room u_room (
		.clk(clk),
		.rst(rst),
		.rob(rob),
		.head(head),
		.tails(tails),
		.room(room)
	);

	// Head pointer and in-order retirement
	rob_commit u_commit (
		.clk(clk),
		.rst(rst),
		.rob(rob),
		.head(head),
		.retire_mask(retire_mask),
		.cmt(cmt)
	);

endmodule

//--- design/rob_commit.sv
// Module rob_commit: head pointer, in-order retirement and the registered commit report
`include "rob_params.svh"

module rob_commit import rob_pkg::*; (
	input logic clk,
	input logic rst,
	input rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output rob_ndx_t head,
	output logic [`ROB_ENTRIES-1:0] retire_mask,
	output cmt_rpt_t cmt
);

	rob_ndx_t head_q;
	// Indexes of the head entry and the ones right behind it
	rob_ndx_t [`ROB_CMT_W-1:0] slot;
	cmt_cnt_t cnt_c;
	// Stays set while every entry scanned so far is ready
	logic run;
	cmt_cnt_t cmt_cnt_q;
	rob_tag_t [`ROB_CMT_W-1:0] cmt_tags_q;

	// ========================================
	// Retire scan
	// ========================================

	// Entries leave strictly in order, so the scan stops at the first entry
	// that is not both valid and done
	always_comb begin
		cnt_c = '0;
		retire_mask = '0;
		run = 1'b1;
		for (int k = 0; k < `ROB_CMT_W; k++) begin
			slot[k] = head_q + rob_ndx_t'(k);
			run = run && rob[slot[k]].v && rob[slot[k]].done;
			if (run) begin
				cnt_c = cnt_c + cmt_cnt_t'(1);
				retire_mask[slot[k]] = 1'b1;
			end
		end
	end

	// Head and the report count move together on the retiring edge
	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			cmt_cnt_q <= '0;
		end
		else begin
			head_q <= head_q + rob_ndx_t'(cnt_c);
			cmt_cnt_q <= cnt_c;
		end
	end

	// Tags are captured every cycle, the count says how many mean anything
	always_ff @(posedge clk) begin
		for (int k = 0; k < `ROB_CMT_W; k++) begin
			cmt_tags_q[k] <= rob[slot[k]].tag;
		end
	end

	assign head = head_q;
	assign cmt.count = cmt_cnt_q;
	assign cmt.tags = cmt_tags_q;

endmodule

//--- design/queue_room.sv
// Module queue_room: sticky empty flag and the room estimate over the tail window
`include "rob_params.svh"

module queue_room import rob_pkg::*; (
	input logic clk,
	input logic rst,
	input rob_entry_t [`ROB_ENTRIES-1:0] rob,
	input rob_ndx_t head,
	input rob_ndx_t [`ROB_WIN-1:0] tails,
	output room_t room
);

	// ========================================
	// Empty flag
	// ========================================

	// Only true from reset until head and tail first part ways
	// After that the buffer is never treated as empty again, even when drained
	logic empty_q;

	always_ff @(posedge clk) begin
		if (rst)
			empty_q <= 1'b1;
		else if (head != tails[0])
			empty_q <= 1'b0;
	end

	// ========================================
	// Free runs
	// ========================================

	// A slot is free when it holds nothing and is not held for an interrupt
	logic [`ROB_ENTRIES-1:0] free;
	// run_free[k] means window slots 0 to k-1 are all free
	logic [`ROB_WIN:0] run_free;
	// run_clear[k] means head is not among window slots 0 to k-1
	logic [`ROB_WIN:0] run_clear;

	always_comb begin
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			free[i] = !rob[i].v && !rob[i].hwi;
		end
	end

	// Both runs grow one slot at a time, so any prefix can be checked
	always_comb begin
		run_free[0] = 1'b1;
		run_clear[0] = 1'b1;
		for (int k = 0; k < `ROB_WIN; k++) begin
			run_free[k+1] = run_free[k] && free[tails[k]];
			run_clear[k+1] = run_clear[k] && (tails[k] != head);
		end
	end

	// ========================================
	// Room rule
	// ========================================

	// Later checks override earlier ones, so the largest qualifying window wins
	always_comb begin
		room = '0;
		if (empty_q)
			room = room_t'(`ROB_ENTRIES - 4);
		// Five free slots leave a spare beyond one group, head overlap allowed
		else if (run_free[`ROB_DISP_W+1])
			room = room_t'(`ROB_DISP_W);
		// Whole groups of four, but only if the run does not reach the head
		for (int k = `ROB_DISP_W; k <= `ROB_WIN; k += `ROB_DISP_W) begin
			if (run_free[k] && run_clear[k])
				room = room_t'(k);
		end
	end

endmodule

//--- design/rob_store.sv
// Module rob_store: entry array with dispatch write, done marking, hold and retire updates
`include "rob_params.svh"

module rob_store import rob_pkg::*; (
	input logic clk,
	input logic rst,
	input disp_req_t disp,
	input rob_ndx_t [`ROB_WIN-1:0] tails,
	input cmpl_t cmpl,
	input hold_t hold,
	input logic [`ROB_ENTRIES-1:0] retire_mask,
	output rob_entry_t [`ROB_ENTRIES-1:0] rob
);

	// ========================================
	// Storage
	// ========================================

	// Flag bits per entry, these are what the room and commit logic look at
	logic [`ROB_ENTRIES-1:0] v_q;
	logic [`ROB_ENTRIES-1:0] done_q;
	logic [`ROB_ENTRIES-1:0] hwi_q;

	// Tag storage, only ever read while the matching valid bit is set
	rob_tag_t tag_q [`ROB_ENTRIES];

	// ========================================
	// Flag updates
	// ========================================

	// Updates are written lowest priority first so that a later assignment
	// to the same bit wins, giving dispatch the final say
	always_ff @(posedge clk) begin
		if (rst) begin
			v_q <= '0;
			done_q <= '0;
			hwi_q <= '0;
		end
		else begin
			// Hold from the interrupt unit, set wins over clear
			if (hold.clr)
				hwi_q[hold.ndx] <= 1'b0;
			if (hold.set)
				hwi_q[hold.ndx] <= 1'b1;

			// A completion only counts against a live entry
			if (cmpl.valid && v_q[cmpl.ndx])
				done_q[cmpl.ndx] <= 1'b1;

			// Retired entries become invalid, hwi is left alone
			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				if (retire_mask[i]) begin
					v_q[i] <= 1'b0;
					done_q[i] <= 1'b0;
				end
			end

			// Dispatch fills the first count slots of the tail window
			for (int j = 0; j < `ROB_DISP_W; j++) begin
				if (disp_cnt_t'(j) < disp.count) begin
					v_q[tails[j]] <= 1'b1;
					done_q[tails[j]] <= 1'b0;
					hwi_q[tails[j]] <= 1'b0;
				end
			end
		end
	end

	// ========================================
	// Tag writes
	// ========================================

	// Tags are plain payload and follow the same slot placement as the flags
	always_ff @(posedge clk) begin
		for (int j = 0; j < `ROB_DISP_W; j++) begin
			if (disp_cnt_t'(j) < disp.count)
				tag_q[tails[j]] <= disp.tags[j];
		end
	end

	// Pack flags and tag back into entry form for the readers
	always_comb begin
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			rob[i].v = v_q[i];
			rob[i].done = done_q[i];
			rob[i].hwi = hwi_q[i];
			rob[i].tag = tag_q[i];
		end
	end

endmodule

//--- design/rob_alloc.sv
// Module rob_alloc: tail pointer register and the window of consecutive tail indexes
`include "rob_params.svh"

module rob_alloc import rob_pkg::*; (
	input logic clk,
	input logic rst,
	input disp_req_t disp,
	output rob_ndx_t tail,
	output rob_ndx_t [`ROB_WIN-1:0] tails
);

	// ========================================
	// Tail pointer
	// ========================================

	// The tail moves forward by however many entries were written this cycle
	// The dispatcher is trusted to stay within room, nothing here checks it
	rob_ndx_t tail_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			tail_q <= '0;
		end
		else begin
			// Wraps naturally at the buffer depth since the index is four bits
			tail_q <= tail_q + rob_ndx_t'(disp.count);
		end
	end

	assign tail = tail_q;

	// ========================================
	// Tail window
	// ========================================

	// Slot k of the window is the k-th entry at or past the tail
	// The store uses the first few slots to place a dispatch group and the
	// room estimator judges how far the free run ahead of the tail reaches
	always_comb begin
		for (int k = 0; k < `ROB_WIN; k++) begin
			// Modulo the depth comes from truncation to the index width
			tails[k] = tail_q + rob_ndx_t'(k);
		end
	end

endmodule

//--- design/rob_pkg.sv
// Package rob_pkg with index, tag and count typedefs and the entry and port structs
`include "rob_params.svh"

package rob_pkg;

	// ========================================
	// Plain vector types
	// ========================================

	// Entry index, wraps modulo the buffer depth
	typedef logic [3:0] rob_ndx_t;
	// Instruction tag carried through to commit
	typedef logic [7:0] rob_tag_t;
	// Room estimate, only 0, 4, 8 or 12 are ever reported
	typedef logic [7:0] room_t;
	// Dispatch count, 0 to 4
	typedef logic [2:0] disp_cnt_t;
	// Commit count, 0 to 2
	typedef logic [1:0] cmt_cnt_t;

	// ========================================
	// Structs
	// ========================================

	// One buffer entry, hwi marks a slot held back for an interrupt
	typedef struct packed {
		logic v;
		logic done;
		logic hwi;
		rob_tag_t tag;
	} rob_entry_t;

	// Dispatch group, tags[0] goes to the tail slot
	typedef struct packed {
		disp_cnt_t count;
		rob_tag_t [`ROB_DISP_W-1:0] tags;
	} disp_req_t;

	// Completion report for one entry
	typedef struct packed {
		logic valid;
		rob_ndx_t ndx;
	} cmpl_t;

	// Hold request from the interrupt unit
	typedef struct packed {
		logic set;
		logic clr;
		rob_ndx_t ndx;
	} hold_t;

	// Commit report, tags[0] is the oldest retired entry
	typedef struct packed {
		cmt_cnt_t count;
		rob_tag_t [`ROB_CMT_W-1:0] tags;
	} cmt_rpt_t;

endpackage

//--- design/rob_params.svh
// Size macros for the reorder buffer: depth, dispatch width, commit width, room window
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// ========================================
// Buffer geometry
// ========================================

// Number of entries in the circular buffer
`define ROB_ENTRIES 16

// Most instructions the dispatcher may write in one cycle
`define ROB_DISP_W 4

// Most done entries the commit stage retires in one cycle
`define ROB_CMT_W 2

// Consecutive tail slots examined by the room estimator
`define ROB_WIN 12

`endif
